//--- design/ice51_defines.svh
`ifndef ICE51_DEFINES_SVH
`define ICE51_DEFINES_SVH

// uart timing, a bit lasts UART_SAMPLE+1 clocks
`define UART_SAMPLE  104

// program image loaded after reset
`define LOAD_BYTES   256
`define CODE_AW      8

// memory mapped transmitter
`define TX_ADDR      16'h0201
`define TX_STAT_ADDR 16'h0200

`endif

//--- design/ice51_pkg.sv
`include "ice51_defines.svh"

package ice51_pkg;

   // kept opcodes, the rn forms carry zero in the low three bits
   typedef enum logic [7:0] {
      OP_LJMP   = 8'h02, OP_INCA   = 8'h04, OP_INCR   = 8'h08, OP_DECA  = 8'h14,
      OP_DECR   = 8'h18, OP_ADDAI  = 8'h24, OP_ADDCI  = 8'h34, OP_JC    = 8'h40,
      OP_ORLAI  = 8'h44, OP_JNC    = 8'h50, OP_ANLAI  = 8'h54, OP_JZ    = 8'h60,
      OP_XRLAI  = 8'h64, OP_JNZ    = 8'h70, OP_MOVAI  = 8'h74, OP_MOVRI = 8'h78,
      OP_SJMP   = 8'h80, OP_MOVDP  = 8'h90, OP_SUBBAI = 8'h94, OP_CLRC  = 8'hC3,
      OP_SETBC  = 8'hD3, OP_DJNZR  = 8'hD8, OP_MOVXAD = 8'hE0, OP_CLRA  = 8'hE4,
      OP_MOVAR  = 8'hE8, OP_MOVXDA = 8'hF0, OP_CPLA   = 8'hF4, OP_MOVRA = 8'hF8
   } op_e;

   typedef struct packed {
      logic [4:0] op5;
      logic [2:0] rn;
   } op_fields_t;

   typedef union packed {
      logic [7:0] raw;
      op_fields_t f;
   } instr_u;

   typedef enum logic [2:0] {
      PH_FETCH, PH_DECODE0, PH_DECODE1, PH_DECODE2, PH_EXECUTE
   } phase_e;

   typedef enum logic [3:0] {
      ALU_MOVE, ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_AND, ALU_OR,
      ALU_XOR, ALU_INC, ALU_DEC, ALU_CLR, ALU_CPL
   } alu_op_e;

   typedef enum logic [1:0] {RN_ACC, RN_IMM, RN_INC, RN_DEC} rn_src_e;
   typedef enum logic [1:0] {ACC_ALU, ACC_REG, ACC_IO} acc_src_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_SJMP, BR_JZ, BR_JNZ, BR_JC, BR_JNC, BR_DJNZ, BR_LJMP
   } branch_e;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       acc_wr;
      logic       carry_wr;
      logic       carry_set_val;   // or'ed into the alu carry
      logic       rn_wr;
      rn_src_e    rn_src;
      acc_src_e   acc_src;
      logic       dptr_wr;
      logic       tx_start;        // movx @dptr,a
      branch_e    branch;
      logic [1:0] nbytes;          // operand bytes after the opcode
   } exec_ctrl_t;

   typedef struct packed {
      logic                en;
      logic [`CODE_AW-1:0] addr;
      logic [7:0]          data;
   } code_wr_t;

endpackage

//--- design/code_store.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module code_store import ice51_pkg::*; (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   input  logic [`CODE_AW-1:0] i_raddr,
   output logic [7:0]          o_rdata,
   output logic                o_load_done
);
   localparam int CW = $clog2(`UART_SAMPLE + 1);

   logic [1:0]          rx_sync;
   rx_state_e           state;
   logic [CW-1:0]       cnt;
   logic [7:0]          shreg;
   logic [`CODE_AW-1:0] byte_cnt;
   logic                full;
   logic                half;
   logic                rx_done;
   code_wr_t            wr;
   logic [7:0]          mem [2**`CODE_AW];

   //////////////////////////////
   // receiver

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         rx_sync <= 2'b11;   // line idles high
      else
         rx_sync <= {rx_sync[0], i_uart_rx};
   end

   assign full    = (cnt == CW'(`UART_SAMPLE));
   assign half    = (cnt == CW'(`UART_SAMPLE / 2));
   assign rx_done = (state == RX_STOP) && full;   // stop bit sample

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync[1])
                  state <= RX_START;
            end
            RX_START: if (half) begin   // middle of start bit
               cnt   <= '0;
               state <= RX_DATA;
            end
            RX_DATA: if (full) begin
               cnt <= '0;
               if (shreg[0])
                  state <= RX_STOP;     // marker reached bit 0, last data bit
            end
            default: if (full) begin
               cnt   <= '0;
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // lsb first, marker walks down from bit 7
   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE)
         shreg <= 8'h80;
      else if (state == RX_DATA && full)
         shreg <= {rx_sync[1], shreg[7:1]};
   end

   //////////////////////////////
   // loader and code ram

   assign wr = '{en: rx_done && !o_load_done, addr: byte_cnt, data: shreg};

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt    <= '0;
         o_load_done <= 1'b0;
      end else if (wr.en) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == `CODE_AW'(`LOAD_BYTES - 1))
            o_load_done <= 1'b1;   // held until reset
      end
   end

   always_ff @(posedge i_clk) begin
      if (wr.en)
         mem[wr.addr] <= wr.data;
      o_rdata <= mem[i_raddr];   // one cycle read latency
   end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module uart_tx import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_data,
   output logic       o_tx,
   output logic       o_busy
);
   localparam int CW = $clog2(`UART_SAMPLE + 1);

   tx_state_e     state;
   logic [CW-1:0] cnt;
   logic [3:0]    bits;
   logic [7:0]    shreg;
   logic          tick;
   logic          finish;

   assign tick   = (cnt == CW'(`UART_SAMPLE));
   assign finish = tick && (bits == 4'd9);   // end of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= TX_IDLE;
         cnt   <= '0;
         bits  <= '0;
      end else begin
         cnt <= (state == TX_IDLE || tick) ? '0 : cnt + 1'b1;
         if (state == TX_IDLE || finish)
            bits <= '0;
         else if (tick)
            bits <= bits + 1'b1;
         case (state)
            TX_IDLE:  if (i_start) state <= TX_START;   // start while busy is dropped
            TX_START: if (tick) state <= TX_SEND;
            default:  if (finish) state <= TX_IDLE;
         endcase
      end
   end

   // msb first, ones fill in behind so the last shifts give the stop bit
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start)
         shreg <= i_data;
      else if (state == TX_SEND && tick)
         shreg <= {shreg[6:0], 1'b1};
   end

   assign o_busy = (state != TX_IDLE);
   assign o_tx   = (state == TX_IDLE) ? 1'b1 : (state == TX_START) ? 1'b0 : shreg[7];

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import ice51_pkg::*; (
   input  instr_u     i_op,
   output exec_ctrl_t o_ctrl
);
   logic    acc_imm;   // a,#imm group
   logic    acc_only;
   logic    op_movxad;
   logic    op_incr;
   logic    op_decr;
   logic    op_movri;
   logic    op_movra;
   logic    op_movar;
   logic    op_djnz;
   alu_op_e alu_sel;
   branch_e br_sel;

   assign acc_imm   = i_op.raw inside {OP_MOVAI, OP_ADDAI, OP_ADDCI, OP_SUBBAI,
                                       OP_ANLAI, OP_ORLAI, OP_XRLAI};
   assign acc_only  = i_op.raw inside {OP_INCA, OP_DECA, OP_CLRA, OP_CPLA};
   assign op_movxad = (i_op.raw == OP_MOVXAD);

   // rn forms match on the upper five bits only
   assign op_incr  = ({i_op.f.op5, 3'b000} == OP_INCR);
   assign op_decr  = ({i_op.f.op5, 3'b000} == OP_DECR);
   assign op_movri = ({i_op.f.op5, 3'b000} == OP_MOVRI);
   assign op_movra = ({i_op.f.op5, 3'b000} == OP_MOVRA);
   assign op_movar = ({i_op.f.op5, 3'b000} == OP_MOVAR);
   assign op_djnz  = ({i_op.f.op5, 3'b000} == OP_DJNZR);

   always_comb begin
      case (i_op.raw)
         OP_ADDAI:  alu_sel = ALU_ADD;
         OP_ADDCI:  alu_sel = ALU_ADDC;
         OP_SUBBAI: alu_sel = ALU_SUBB;
         OP_ANLAI:  alu_sel = ALU_AND;
         OP_ORLAI:  alu_sel = ALU_OR;
         OP_XRLAI:  alu_sel = ALU_XOR;
         OP_INCA:   alu_sel = ALU_INC;
         OP_DECA:   alu_sel = ALU_DEC;
         OP_CLRA:   alu_sel = ALU_CLR;
         OP_CPLA:   alu_sel = ALU_CPL;
         default:   alu_sel = ALU_MOVE;   // also clr c / setb c, carry out is zero
      endcase
   end

   always_comb begin
      case (i_op.raw)
         OP_SJMP: br_sel = BR_SJMP;
         OP_JZ:   br_sel = BR_JZ;
         OP_JNZ:  br_sel = BR_JNZ;
         OP_JC:   br_sel = BR_JC;
         OP_JNC:  br_sel = BR_JNC;
         OP_LJMP: br_sel = BR_LJMP;
         default: br_sel = op_djnz ? BR_DJNZ : BR_NONE;
      endcase
   end

   // unknown opcodes fall out as all zero, a one byte nop
   always_comb begin
      o_ctrl.alu_op        = alu_sel;
      o_ctrl.acc_wr        = acc_imm | acc_only | op_movar | op_movxad;
      o_ctrl.carry_wr      = i_op.raw inside {OP_ADDAI, OP_ADDCI, OP_SUBBAI, OP_CLRC, OP_SETBC};
      o_ctrl.carry_set_val = (i_op.raw == OP_SETBC);
      o_ctrl.rn_wr         = op_incr | op_decr | op_movri | op_movra | op_djnz;
      o_ctrl.rn_src        = op_movri ? RN_IMM :
                             op_incr  ? RN_INC :
                             (op_decr | op_djnz) ? RN_DEC : RN_ACC;
      o_ctrl.acc_src       = op_movar ? ACC_REG : op_movxad ? ACC_IO : ACC_ALU;
      o_ctrl.dptr_wr       = (i_op.raw == OP_MOVDP);
      o_ctrl.tx_start      = (i_op.raw == OP_MOVXDA);
      o_ctrl.branch        = br_sel;
      if (br_sel == BR_LJMP || i_op.raw == OP_MOVDP)
         o_ctrl.nbytes = 2'd2;
      else if (acc_imm || op_movri || br_sel != BR_NONE)
         o_ctrl.nbytes = 2'd1;   // imm or rel
      else
         o_ctrl.nbytes = 2'd0;
   end

endmodule

//--- design/cpu_sequencer.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module cpu_sequencer import ice51_pkg::*; (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_load_done,
   input  logic [7:0]          i_code,
   input  exec_ctrl_t          i_ctrl,
   input  logic                i_acc_zero,
   input  logic                i_carry,
   input  logic                i_rn_zero_next,
   output instr_u              o_op,
   output logic [`CODE_AW-1:0] o_raddr,
   output logic [7:0]          o_imm_h,
   output logic [7:0]          o_imm_l,
   output phase_e              o_phase
);
   logic [`CODE_AW-1:0] pc;
   logic [`CODE_AW-1:0] pc_next;
   logic [7:0]          op_q;
   phase_e              phase_next;
   logic                step;    // pc moves to the next code byte
   logic                taken;

   assign o_raddr  = pc;
   assign o_op.raw = (o_phase == PH_DECODE0) ? i_code : op_q;   // opcode straight from ram

   //////////////////////////////
   // phases

   always_comb begin
      phase_next = o_phase;
      step       = 1'b0;
      case (o_phase)
         PH_FETCH: if (i_load_done) begin   // parked here while loading
            phase_next = PH_DECODE0;
            step       = 1'b1;
         end
         PH_DECODE0: begin
            step       = (i_ctrl.nbytes != 2'd0);
            phase_next = step ? PH_DECODE1 : PH_EXECUTE;
         end
         PH_DECODE1: begin
            step       = (i_ctrl.nbytes == 2'd2);
            phase_next = step ? PH_DECODE2 : PH_EXECUTE;
         end
         PH_DECODE2: phase_next = PH_EXECUTE;
         default:    phase_next = PH_FETCH;
      endcase
   end

   //////////////////////////////
   // branches and pc

   always_comb begin
      case (i_ctrl.branch)
         BR_SJMP: taken = 1'b1;
         BR_JZ:   taken = i_acc_zero;
         BR_JNZ:  taken = !i_acc_zero;
         BR_JC:   taken = i_carry;
         BR_JNC:  taken = !i_carry;
         BR_DJNZ: taken = !i_rn_zero_next;
         default: taken = 1'b0;
      endcase
   end

   // pc already points past the instruction in execute
   always_comb begin
      pc_next = pc;
      if (step)
         pc_next = pc + 1'b1;
      if (o_phase == PH_EXECUTE) begin
         if (i_ctrl.branch == BR_LJMP)
            pc_next = o_imm_l[`CODE_AW-1:0];           // low address byte only
         else if (taken)
            pc_next = pc + o_imm_h[`CODE_AW-1:0];      // wraps mod 256
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_phase <= PH_FETCH;
         pc      <= '0;
      end else begin
         o_phase <= phase_next;
         pc      <= pc_next;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_phase == PH_DECODE0)
         op_q <= i_code;
      if (o_phase == PH_DECODE1)
         o_imm_h <= i_code;
      if (o_phase == PH_DECODE2)
         o_imm_l <= i_code;
   end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu import ice51_pkg::*; (
   input  alu_op_e    i_op,
   input  logic [7:0] i_acc,
   input  logic [7:0] i_operand,
   input  logic       i_carry,
   output logic [7:0] o_result,
   output logic       o_carry
);
   logic       cin;
   logic [8:0] sum;
   logic [8:0] diff;

   assign cin  = (i_op == ALU_ADDC || i_op == ALU_SUBB) ? i_carry : 1'b0;
   assign sum  = {1'b0, i_acc} + {1'b0, i_operand} + {8'd0, cin};
   assign diff = {1'b0, i_acc} - {1'b0, i_operand} - {8'd0, cin};   // bit 8 is the borrow

   always_comb begin
      case (i_op)
         ALU_ADD, ALU_ADDC: o_result = sum[7:0];
         ALU_SUBB: o_result = diff[7:0];
         ALU_AND:  o_result = i_acc & i_operand;
         ALU_OR:   o_result = i_acc | i_operand;
         ALU_XOR:  o_result = i_acc ^ i_operand;
         ALU_INC:  o_result = i_acc + 8'd1;
         ALU_DEC:  o_result = i_acc - 8'd1;
         ALU_CLR:  o_result = 8'd0;
         ALU_CPL:  o_result = ~i_acc;
         default:  o_result = i_operand;
      endcase
   end

   // only add, addc and subb produce a carry
   assign o_carry = (i_op == ALU_ADD || i_op == ALU_ADDC) ? sum[8] :
                    (i_op == ALU_SUBB) ? diff[8] : 1'b0;

endmodule

//--- design/core_regs.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module core_regs import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  phase_e     i_phase,
   input  exec_ctrl_t i_ctrl,
   input  logic [2:0] i_rn,
   input  logic [7:0] i_imm_h,
   input  logic [7:0] i_imm_l,
   input  logic [7:0] i_alu_result,
   input  logic       i_alu_carry,
   input  logic       i_tx_busy,
   output logic [7:0] o_acc,
   output logic       o_carry,
   output logic       o_acc_zero,
   output logic       o_rn_zero_next,
   output logic       o_tx_start,
   output logic [7:0] o_rn_data
);
   logic [7:0]  rf [8];   // r0..r7
   logic [15:0] dptr;
   logic [7:0]  rn_wdata;
   logic [7:0]  io_rdata;
   logic [7:0]  acc_next;
   logic        exec;

   assign exec       = (i_phase == PH_EXECUTE);
   assign o_rn_data  = rf[i_rn];
   assign o_acc_zero = (o_acc == 8'd0);

   //////////////////////////////
   // working registers

   always_comb begin
      case (i_ctrl.rn_src)
         RN_IMM:  rn_wdata = i_imm_h;
         RN_INC:  rn_wdata = o_rn_data + 8'd1;
         RN_DEC:  rn_wdata = o_rn_data - 8'd1;
         default: rn_wdata = o_acc;
      endcase
   end

   assign o_rn_zero_next = (rn_wdata == 8'd0);   // djnz falls through on zero

   always_ff @(posedge i_clk) begin
      if (exec && i_ctrl.rn_wr)
         rf[i_rn] <= rn_wdata;
   end

   //////////////////////////////
   // acc, carry, dptr and i/o

   assign io_rdata   = (dptr == `TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'd0;
   assign o_tx_start = exec && i_ctrl.tx_start && (dptr == `TX_ADDR);

   always_comb begin
      case (i_ctrl.acc_src)
         ACC_REG: acc_next = o_rn_data;
         ACC_IO:  acc_next = io_rdata;
         default: acc_next = i_alu_result;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_acc   <= 8'd0;
         o_carry <= 1'b0;
         dptr    <= 16'd0;
      end else if (exec) begin
         if (i_ctrl.acc_wr)
            o_acc <= acc_next;
         if (i_ctrl.carry_wr)
            o_carry <= i_alu_carry | i_ctrl.carry_set_val;   // setb c forces one
         if (i_ctrl.dptr_wr)
            dptr <= {i_imm_h, i_imm_l};
      end
   end

endmodule

//--- design/ice51_top.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_top import ice51_pkg::*; (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);
   logic [`CODE_AW-1:0] raddr;
   logic [7:0]          rdata;
   logic                load_done;
   instr_u              op;
   exec_ctrl_t          ctrl;
   phase_e              phase;
   logic [7:0]          imm_h;
   logic [7:0]          imm_l;
   logic [7:0]          acc;
   logic                carry;
   logic                acc_zero;
   logic                rn_zero_next;
   logic [7:0]          alu_result;
   logic                alu_carry;
   logic                tx_start;
   logic                tx_busy;

   code_store u_code_store (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .i_raddr     (raddr),
      .o_rdata     (rdata),
      .o_load_done (load_done)
   );

   cpu_sequencer u_seq (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_load_done    (load_done),
      .i_code         (rdata),
      .i_ctrl         (ctrl),
      .i_acc_zero     (acc_zero),
      .i_carry        (carry),
      .i_rn_zero_next (rn_zero_next),
      .o_op           (op),
      .o_raddr        (raddr),
      .o_imm_h        (imm_h),
      .o_imm_l        (imm_l),
      .o_phase        (phase)
   );

   instr_decoder u_dec (
      .i_op   (op),
      .o_ctrl (ctrl)
   );

   alu u_alu (
      .i_op      (ctrl.alu_op),
      .i_acc     (acc),
      .i_operand (imm_h),
      .i_carry   (carry),
      .o_result  (alu_result),
      .o_carry   (alu_carry)
   );

   core_regs u_regs (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_phase        (phase),
      .i_ctrl         (ctrl),
      .i_rn           (op.f.rn),
      .i_imm_h        (imm_h),
      .i_imm_l        (imm_l),
      .i_alu_result   (alu_result),
      .i_alu_carry    (alu_carry),
      .i_tx_busy      (tx_busy),
      .o_acc          (acc),
      .o_carry        (carry),
      .o_acc_zero     (acc_zero),
      .o_rn_zero_next (rn_zero_next),
      .o_tx_start     (tx_start),
      .o_rn_data      ()
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_data  (acc),
      .o_tx    (o_uart_tx),
      .o_busy  (tx_busy)
   );

endmodule

//--- bench/ice51_assert.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_assert import ice51_pkg::*; (
   input logic     i_clk,
   input logic     i_nrst,
   input logic     i_load_done,
   input logic     i_uart_tx,
   input phase_e   i_phase,
   input code_wr_t i_wr
);
   int unsigned n_writes;   // code writes since reset

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         n_writes <= 0;
      else if (i_wr.en)
         n_writes <= n_writes + 1;
   end

   // line idles until the image is in
   tx_idle_loading: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_load_done |-> i_uart_tx)
      else $error("o_uart_tx left idle while the code image was loading");

   fetch_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_load_done |-> i_phase == PH_FETCH)   // cpu parked
      else $error("cpu left FETCH before the load finished");

   no_late_write: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_load_done |-> !i_wr.en && n_writes == `LOAD_BYTES)
      else $error("load done without a full image or code ram written after it");

endmodule

bind ice51_top ice51_assert u_assert (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_load_done (load_done),
   .i_uart_tx   (o_uart_tx),
   .i_phase     (phase),
   .i_wr        (u_code_store.wr)
);

//--- bench/ice51_tb.sv
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_tb import ice51_pkg::*; ();

   localparam logic [15:0] STAT_ADDR   = `TX_STAT_ADDR;
   localparam logic [15:0] TX_DATA_ADR = `TX_ADDR;
   localparam int          BIT_CLKS    = `UART_SAMPLE + 1;
   localparam int          LOAD_CLOCKS = `LOAD_BYTES * 10 * BIT_CLKS;

   logic       i_clk;
   logic       i_nrst;
   logic       i_uart_rx;
   logic       o_uart_tx;

   logic [7:0] image [`LOAD_BYTES];
   logic [7:0] wp;            // next free image address
   logic [7:0] exp_q [$];     // bytes the program should transmit
   logic       model_c;       // carry as the program should see it
   integer     seed = 81;

   ice51_top i_dut (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   //////////////////////////////
   // reporting

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   function automatic logic [7:0] rand8();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   //////////////////////////////
   // uart line

   // 8N1, lsb first into the loader
   task automatic uart_send(input logic [7:0] data, input bit check_line);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      repeat (10) begin
         i_uart_rx = frame[0];
         frame     = frame >> 1;
         repeat (BIT_CLKS) @(negedge i_clk);
      end
      if (check_line)
         check_value("o_uart_tx during load", {7'd0, o_uart_tx}, 8'h01);
   endtask

   // transmitter sends msb first
   task automatic uart_recv(output logic [7:0] data, input int limit);
      int waited;
      waited = 0;
      while (o_uart_tx === 1'b1) begin
         @(negedge i_clk);
         waited++;
         if (waited > limit)
            report_failure("timed out waiting for a start bit on o_uart_tx");
      end
      repeat (BIT_CLKS / 2) @(negedge i_clk);   // middle of start bit
      if (o_uart_tx !== 1'b0)
         report_failure("start bit on o_uart_tx did not stay low");
      data = 8'h00;
      repeat (8) begin
         repeat (BIT_CLKS) @(negedge i_clk);
         data = {data[6:0], o_uart_tx};
      end
      repeat (BIT_CLKS) @(negedge i_clk);
      if (o_uart_tx !== 1'b1)
         report_failure("stop bit on o_uart_tx was not high");
   endtask

   //////////////////////////////
   // program image

   task automatic emit(input logic [7:0] b);
      image[wp] = b;
      wp = wp + 8'd1;
   endtask

   task automatic emit2(input logic [7:0] b0, input logic [7:0] b1);
      emit(b0);
      emit(b1);
   endtask

   function automatic logic [7:0] rn_op(input op_e base, input logic [2:0] n);
      logic [7:0] b;
      b = base;
      return {b[7:3], n};
   endfunction

   task automatic start_image();
      for (int i = 0; i < `LOAD_BYTES; i++)
         image[i[7:0]] = 8'h00;   // nop padding
      wp = 8'd0;
      exp_q.delete();
   endtask

   // a parked in r7, poll busy, then write a to the tx register
   task automatic emit_send();
      emit(rn_op(OP_MOVRA, 3'd7));
      emit(OP_MOVDP);
      emit(STAT_ADDR[15:8]);
      emit(STAT_ADDR[7:0]);
      emit(OP_MOVXAD);
      emit2(OP_JNZ, 8'hFD);       // back to the movx
      emit(rn_op(OP_MOVAR, 3'd7));
      emit(OP_MOVDP);
      emit(TX_DATA_ADR[15:8]);
      emit(TX_DATA_ADR[7:0]);
      emit(OP_MOVXDA);
   endtask

   task automatic send_acc(input logic [7:0] expect_val);
      emit_send();
      exp_q.push_back(expect_val);
   endtask

   task automatic send_const(input logic [7:0] v);
      emit2(OP_MOVAI, v);
      send_acc(v);
   endtask

   task automatic load_image();
      for (int i = 0; i < `LOAD_BYTES; i++)
         uart_send(image[i[7:0]], i != `LOAD_BYTES - 1);
   endtask

   task automatic collect_bytes(input string name);
      logic [7:0] got;
      int         limit;
      for (int i = 0; i < exp_q.size(); i++) begin
         limit = (i == 0) ? LOAD_CLOCKS + 20000 : 20000;
         uart_recv(got, limit);
         check_value($sformatf("%s o_uart_tx byte %0d", name, i), got, exp_q[i]);
      end
   endtask

   task automatic run_image(input string name);
      emit2(OP_SJMP, 8'hFE);   // park the cpu
      @(negedge i_clk);
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      repeat (3) @(negedge i_clk);
      i_nrst = 1'b1;
      check_value($sformatf("%s o_uart_tx after reset", name), {7'd0, o_uart_tx}, 8'h01);
      fork
         load_image();
         collect_bytes(name);
      join
   endtask

   //////////////////////////////
   // accumulator model and marker paths

   task automatic acc_op(input op_e op, input logic [7:0] a0, input logic [7:0] imm);
      logic [8:0] wide;
      logic [7:0] res;
      logic       cin;
      emit2(OP_MOVAI, a0);
      if (op inside {OP_INCA, OP_DECA, OP_CLRA, OP_CPLA})
         emit(op);
      else
         emit2(op, imm);
      case (op)
         OP_ADDAI, OP_ADDCI: begin
            cin     = (op == OP_ADDCI) ? model_c : 1'b0;
            wide    = {1'b0, a0} + {1'b0, imm} + {8'd0, cin};
            res     = wide[7:0];
            model_c = wide[8];
         end
         OP_SUBBAI: begin
            res     = a0 - imm - {7'd0, model_c};
            model_c = ({1'b0, a0} < {1'b0, imm} + {8'd0, model_c});   // borrow
         end
         OP_ANLAI: res = a0 & imm;
         OP_ORLAI: res = a0 | imm;
         OP_XRLAI: res = a0 ^ imm;
         OP_INCA:  res = a0 + 8'd1;
         OP_DECA:  res = a0 - 8'd1;
         OP_CPLA:  res = ~a0;
         default:  res = 8'h00;
      endcase
      send_acc(res);
   endtask

   // jc or jnc picks between two markers
   task automatic carry_marker(input op_e jop);
      logic taken;
      taken = (jop == OP_JC) ? model_c : !model_c;
      emit2(jop, 8'h04);
      emit2(OP_MOVAI, 8'h0C);
      emit2(OP_SJMP, 8'h02);
      emit2(OP_MOVAI, 8'hC1);
      send_acc(taken ? 8'hC1 : 8'h0C);
   endtask

   // taken skips the dead mov and lands on the marker
   task automatic branch_taken(input op_e jop, input logic [7:0] marker);
      emit2(jop, 8'h04);
      emit2(OP_MOVAI, 8'hEE);
      emit2(OP_SJMP, 8'h02);
      send_const(marker);
   endtask

   task automatic branch_not(input op_e jop, input logic [7:0] marker);
      emit2(jop, 8'h02);
      send_const(marker);
   endtask

   //////////////////////////////
   // tests

   task automatic test_idle_line();
      start_image();
      emit2(rn_op(OP_MOVRI, 3'd3), 8'd40);
      emit2(rn_op(OP_DJNZR, 3'd3), 8'hFE);   // short delay before first movx
      send_const(8'h5A);
      run_image("idle_line");
   endtask

   task automatic test_acc_ops();
      start_image();
      emit(OP_CLRC);
      model_c = 1'b0;
      acc_op(OP_ADDAI, rand8() | 8'h80, rand8() | 8'h80);
      carry_marker(OP_JC);
      acc_op(OP_ADDCI, rand8() & 8'h3F, rand8() & 8'h3F);
      carry_marker(OP_JNC);
      emit(OP_SETBC);
      model_c = 1'b1;
      acc_op(OP_SUBBAI, rand8(), rand8());
      carry_marker(OP_JC);
      acc_op(OP_ANLAI, rand8(), rand8());
      acc_op(OP_ORLAI, rand8(), rand8());
      acc_op(OP_XRLAI, rand8(), rand8());
      acc_op(OP_INCA, rand8(), 8'h00);
      acc_op(OP_DECA, rand8(), 8'h00);
      acc_op(OP_CPLA, rand8(), 8'h00);
      acc_op(OP_CLRA, rand8() | 8'h01, 8'h00);
      run_image("acc_ops");
   endtask

   task automatic test_registers();
      logic [7:0] r0;
      logic [7:0] r1;
      logic [7:0] r2;
      r0 = rand8();
      r1 = rand8();
      r2 = rand8();
      start_image();
      emit2(rn_op(OP_MOVRI, 3'd0), r0);
      emit2(rn_op(OP_MOVRI, 3'd1), r1);
      emit(rn_op(OP_INCR, 3'd0));
      emit(rn_op(OP_DECR, 3'd1));
      emit(rn_op(OP_MOVAR, 3'd0));
      send_acc(r0 + 8'd1);
      emit(rn_op(OP_MOVAR, 3'd1));
      send_acc(r1 - 8'd1);
      emit2(OP_MOVAI, r2);
      emit(rn_op(OP_MOVRA, 3'd3));
      emit(rn_op(OP_INCR, 3'd3));
      emit(OP_CLRA);
      emit(rn_op(OP_MOVAR, 3'd3));
      send_acc(r2 + 8'd1);
      emit2(rn_op(OP_MOVRI, 3'd5), 8'hFF);
      emit(rn_op(OP_INCR, 3'd5));        // wraps to zero
      emit(rn_op(OP_MOVAR, 3'd5));
      send_acc(8'h00);
      emit2(rn_op(OP_MOVRI, 3'd6), 8'h00);
      emit(rn_op(OP_DECR, 3'd6));
      emit(rn_op(OP_MOVAR, 3'd6));
      send_acc(8'hFF);
      emit(rn_op(OP_MOVAR, 3'd0));       // r0 untouched by later writes
      send_acc(r0 + 8'd1);
      run_image("registers");
   endtask

   task automatic test_djnz();
      logic [7:0] n;
      n = (rand8() % 8'd20) + 8'd1;
      start_image();
      emit(OP_CLRA);
      emit2(rn_op(OP_MOVRI, 3'd2), n);
      emit(OP_INCA);
      emit2(rn_op(OP_DJNZR, 3'd2), 8'hFD);   // back to inc a
      send_acc(n);
      run_image("djnz");
   endtask

   task automatic test_branches();
      logic [7:0] back;
      logic [7:0] tgt;
      start_image();
      branch_taken(OP_SJMP, 8'hB1);
      emit(OP_CLRA);
      branch_taken(OP_JZ, 8'hB2);
      branch_not(OP_JZ, 8'hB3);
      branch_taken(OP_JNZ, 8'hB4);
      emit(OP_CLRA);
      branch_not(OP_JNZ, 8'hB5);
      tgt = wp + 8'd7;
      emit(OP_LJMP);
      emit(8'h12);                      // high byte ignored
      emit(tgt);
      emit2(OP_MOVAI, 8'hEE);
      emit2(OP_SJMP, 8'h02);
      send_const(8'hB6);
      // forward over a block, then back into it
      emit2(OP_SJMP, 8'd16);
      back = wp;
      emit2(OP_MOVAI, 8'hB8);
      emit_send();
      emit2(OP_SJMP, 8'hFE);
      emit2(OP_MOVAI, 8'hB7);
      emit_send();
      emit2(OP_SJMP, back - (wp + 8'd2));
      exp_q.push_back(8'hB7);
      exp_q.push_back(8'hB8);
      run_image("branches");
   endtask

   task automatic test_back_to_back();
      start_image();
      for (int i = 0; i < 4; i++)
         send_const(rand8() | 8'h01);
      emit(OP_MOVDP);
      emit(8'h12);
      emit(8'h34);
      emit(OP_MOVXAD);                  // unmapped read gives zero
      send_acc(8'h00);
      run_image("back_to_back");
   endtask

   initial begin
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      model_c   = 1'b0;
      test_idle_line();
      test_acc_ops();
      test_registers();
      test_djnz();
      test_branches();
      test_back_to_back();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- files.f
+incdir+design
design/ice51_pkg.sv
design/code_store.sv
design/uart_tx.sv
design/instr_decoder.sv
design/cpu_sequencer.sv
design/alu.sv
design/core_regs.sv
design/ice51_top.sv
bench/ice51_assert.sv
bench/ice51_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       := ice51_tb
FILELIST  := files.f
BUILD_DIR := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
